//--- logic/branchConsts.svh
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

// pc and operand width
`define BR_PC_W 32

// predictor index, taken from pc[7:2]
`define BR_IDX_W 6

// counters start weakly not-taken
`define BR_CTR_INIT 2'b01

// fall-through skips the delay slot
`define BR_SLOT_OFS 8

`endif

//--- logic/branchPkg.sv
`include "branchConsts.svh"

package branchPkg;

    typedef logic [`BR_PC_W-1:0]  pcT;    // pc or operand value
    typedef logic [1:0]           ctrT;   // two-bit saturating counter
    typedef logic [`BR_IDX_W-1:0] idxT;   // predictor table index

    // primary opcodes of the branches handled here
    typedef enum logic [5:0] {
        OP_REGIMM = 6'b000001,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111
    } mipsOpE;

    // resolved condition kind
    // under regimm, rt 00000 is bltz and rt 00001 is bgez
    typedef enum logic [2:0] {
        COND_NONE,
        COND_EQ,
        COND_NE,
        COND_LEZ,
        COND_GTZ,
        COND_LTZ,
        COND_GEZ
    } brCondE;

    localparam logic [4:0] RT_LTZ = 5'b00000;
    localparam logic [4:0] RT_GEZ = 5'b00001;

endpackage

//--- logic/predIf.sv
`include "branchConsts.svh"

interface predIf
    import branchPkg::*;
();

    logic valid;       // e-stage prediction holds an instruction
    pcT   pc;          // pc of that instruction
    pcT   target;      // taken target
    logic predTaken;
    idxT  idx;         // table index it was read from
    ctrT  ctr;         // counter value seen at read time

    modport pred (
        output valid, pc, target, predTaken, idx, ctr
    );

    modport redir (
        input valid, pc, target, predTaken, idx, ctr
    );

endinterface

//--- logic/branchPredictor.sv
`include "branchConsts.svh"

module branchPredictor
    import branchPkg::*;
(
    input  logic        clk_i,
    input  logic        arstN_i,
    input  logic        accept_i,
    input  logic        stall_i,
    input  pcT          pc_i,
    input  logic [31:0] instr_i,
    input  logic        updValid_i,
    input  idxT         updIdx_i,
    input  ctrT         updCtr_i,
    predIf.pred         pred_o
);

    localparam int Entries = 1 << `BR_IDX_W;

    ctrT ctrTable [Entries];
    idxT rdIdx;
    ctrT rdCtr;
    pcT  immOfs;
    pcT  target;

    // word-aligned pc, low bits dropped
    assign rdIdx = pc_i[`BR_IDX_W+1:2];

    // same-edge update wins over the stored counter
    assign rdCtr = (updValid_i && (updIdx_i == rdIdx)) ? updCtr_i : ctrTable[rdIdx];

    // sign-extended offset in words
    assign immOfs = {{(`BR_PC_W-18){instr_i[15]}}, instr_i[15:0], 2'b00};
    assign target = pc_i + pcT'(4) + immOfs;   // relative to the delay slot

    // counter table
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < Entries; i++) begin
                ctrTable[i] <= `BR_CTR_INIT;
            end
        end else if (updValid_i) begin
            ctrTable[updIdx_i] <= updCtr_i;
        end
    end

    // e-stage valid, held while stalled
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pred_o.valid <= 1'b0;
        end else if (accept_i) begin
            pred_o.valid <= 1'b1;
        end else if (!stall_i) begin
            pred_o.valid <= 1'b0;   // drained into the redirect unit
        end
    end

    // prediction payload
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            pred_o.pc        <= pc_i;
            pred_o.target    <= target;
            pred_o.idx       <= rdIdx;
            pred_o.ctr       <= rdCtr;
            pred_o.predTaken <= rdCtr[1];   // upper bit is the guess
        end
    end

    // index of a training write is always resolved
    updIdxKnown: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        updValid_i |-> !$isunknown(updIdx_i)
    );

endmodule

//--- logic/branchCondCheck.sv
`include "branchConsts.svh"

module branchCondCheck
    import branchPkg::*;
(
    input  logic        clk_i,
    input  logic        arstN_i,
    input  logic        accept_i,
    input  logic        stall_i,
    input  logic [31:0] instr_i,
    input  pcT          rsVal_i,
    input  pcT          rtVal_i,
    output logic        chkValid_o,
    output logic        isBranch_o,
    output logic        actualTaken_o
);

    mipsOpE     opcode;
    logic [4:0] rtField;
    brCondE     condKind;
    logic       takenNow;

    assign opcode  = mipsOpE'(instr_i[31:26]);
    assign rtField = instr_i[20:16];

    // branch kind decode
    always_comb begin
        case (opcode)
            OP_BEQ:  condKind = COND_EQ;
            OP_BNE:  condKind = COND_NE;
            OP_BLEZ: condKind = COND_LEZ;
            OP_BGTZ: condKind = COND_GTZ;
            OP_REGIMM: begin
                if (rtField == RT_LTZ) condKind = COND_LTZ;
                else if (rtField == RT_GEZ) condKind = COND_GEZ;
                else condKind = COND_NONE;   // link forms not handled
            end
            default: condKind = COND_NONE;
        endcase
    end

    // zero compares are signed, eq/ne are bitwise
    always_comb begin
        case (condKind)
            COND_EQ:  takenNow = (rsVal_i == rtVal_i);
            COND_NE:  takenNow = (rsVal_i != rtVal_i);
            COND_LEZ: takenNow = ($signed(rsVal_i) <= 0);
            COND_GTZ: takenNow = ($signed(rsVal_i) > 0);
            COND_LTZ: takenNow = ($signed(rsVal_i) < 0);
            COND_GEZ: takenNow = ($signed(rsVal_i) >= 0);
            default:  takenNow = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            chkValid_o <= 1'b0;
        end else if (accept_i) begin
            chkValid_o <= 1'b1;
        end else if (!stall_i) begin
            chkValid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            isBranch_o    <= (condKind != COND_NONE);
            actualTaken_o <= takenNow;
        end
    end

    // a non-branch never resolves taken
    noneNotTaken: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        (chkValid_o && !isBranch_o) |-> !actualTaken_o
    );

endmodule

//--- logic/redirectUnit.sv
`include "branchConsts.svh"

module redirectUnit
    import branchPkg::*;
(
    input  logic  clk_i,
    input  logic  arstN_i,
    input  logic  stall_i,
    input  logic  chkValid_i,
    input  logic  isBranch_i,
    input  logic  actualTaken_i,
    predIf.redir  pred_i,
    output logic  updValid_o,
    output idxT   updIdx_o,
    output ctrT   updCtr_o,
    output logic  resValid_o,
    output pcT    resPc_o,
    output logic  actualTaken_o,
    output logic  mispredict_o,
    output pcT    redirectPc_o
);

    logic fire;
    logic effPred;
    logic missNow;
    pcT   redirNow;

    // e-stage result moves on only when not stalled
    assign fire    = !stall_i && pred_i.valid && chkValid_i;
    assign effPred = isBranch_i && pred_i.predTaken;   // non-branch falls through
    assign missNow = (effPred != actualTaken_i);

    // taken goes to target, else past the delay slot
    assign redirNow = actualTaken_i ? pred_i.target : pred_i.pc + pcT'(`BR_SLOT_OFS);

    // training, one step toward the outcome
    assign updValid_o = fire && isBranch_i;
    assign updIdx_o   = pred_i.idx;

    always_comb begin
        if (actualTaken_i) begin
            updCtr_o = (pred_i.ctr == 2'b11) ? pred_i.ctr : pred_i.ctr + 2'd1;
        end else begin
            updCtr_o = (pred_i.ctr == 2'b00) ? pred_i.ctr : pred_i.ctr - 2'd1;
        end
    end

    // bubble while stalled so each result shows once
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            resValid_o   <= 1'b0;
            mispredict_o <= 1'b0;
        end else begin
            resValid_o   <= fire;
            mispredict_o <= fire && missNow;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            resPc_o       <= pred_i.pc;
            actualTaken_o <= actualTaken_i;
            redirectPc_o  <= redirNow;
        end
    end

    missHasResult: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        mispredict_o |-> resValid_o
    );

    // predictor and checker stages move in lockstep
    validsAgree: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        pred_i.valid == chkValid_i
    );

endmodule

//--- logic/branchUnit.sv
`include "branchConsts.svh"

module branchUnit
    import branchPkg::*;
(
    input  logic        clk_i,
    input  logic        arstN_i,
    input  logic        valid_i,
    input  logic        stall_i,
    input  pcT          pc_i,
    input  logic [31:0] instr_i,
    input  pcT          rsVal_i,
    input  pcT          rtVal_i,
    output logic        resValid_o,
    output pcT          resPc_o,
    output logic        actualTaken_o,
    output logic        mispredict_o,
    output pcT          redirectPc_o
);

    logic accept;
    logic chkValid;
    logic isBranch;
    logic chkTaken;
    logic updValid;
    idxT  updIdx;
    ctrT  updCtr;

    predIf predBus ();

    assign accept = valid_i && !stall_i;   // e-stage load enable

    branchPredictor u_pred (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .accept_i   (accept),
        .stall_i    (stall_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .updValid_i (updValid),
        .updIdx_i   (updIdx),
        .updCtr_i   (updCtr),
        .pred_o     (predBus.pred)
    );

    branchCondCheck u_chk (
        .clk_i         (clk_i),
        .arstN_i       (arstN_i),
        .accept_i      (accept),
        .stall_i       (stall_i),
        .instr_i       (instr_i),
        .rsVal_i       (rsVal_i),
        .rtVal_i       (rtVal_i),
        .chkValid_o    (chkValid),
        .isBranch_o    (isBranch),
        .actualTaken_o (chkTaken)
    );

    redirectUnit u_redir (
        .clk_i         (clk_i),
        .arstN_i       (arstN_i),
        .stall_i       (stall_i),
        .chkValid_i    (chkValid),
        .isBranch_i    (isBranch),
        .actualTaken_i (chkTaken),
        .pred_i        (predBus.redir),
        .updValid_o    (updValid),
        .updIdx_o      (updIdx),
        .updCtr_o      (updCtr),
        .resValid_o    (resValid_o),
        .resPc_o       (resPc_o),
        .actualTaken_o (actualTaken_o),
        .mispredict_o  (mispredict_o),
        .redirectPc_o  (redirectPc_o)
    );

endmodule

//--- verification/clkGen.sv
module clkGen (
    output logic clk_o,
    output logic arstN_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod  = 20;   // 40 ns clock
    localparam int ResetCycles = 4;

    initial begin
        clk_o = 1'b0;
        forever #HalfPeriod clk_o = ~clk_o;
    end

    initial begin
        arstN_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        #2 arstN_o = 1'b1;   // release clear of the edge
    end

endmodule

//--- verification/branchUnitTb.sv
`include "branchConsts.svh"

module branchUnitTb
    import branchPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] Seed = 32'h565ce1d5;
    localparam int MaxGap       = 3;    // idle or stalled cycles before an accept
    localparam int NumPasses    = 2;
    localparam int ClkPeriod    = 40;
    localparam int DriveDelay   = 2;
    localparam int DrainLimit   = 8;
    localparam int MarginCycles = 40;

    logic        clk;
    logic        arstN;
    logic        valid_i;
    logic        stall_i;
    pcT          pc_i;
    logic [31:0] instr_i;
    pcT          rsVal_i;
    pcT          rtVal_i;
    logic        resValid_o;
    pcT          resPc_o;
    logic        actualTaken_o;
    logic        mispredict_o;
    pcT          redirectPc_o;

    // stimulus table, one row per instruction
    string       tabName[$];
    pcT          tabPc[$];
    logic [31:0] tabInstr[$];
    pcT          tabRs[$];
    pcT          tabRt[$];
    logic        tabTaken[$];   // hand-derived outcome
    bit          tabBurst[$];   // no gap before this row

    // expected results in issue order
    string expName[$];
    pcT    expPc[$];
    logic  expTaken[$];
    logic  expMiss[$];
    pcT    expRedir[$];

    ctrT refCtr [64];   // reference counter table
    bit  tableReady;

    clkGen u_clk (
        .clk_o   (clk),
        .arstN_o (arstN)
    );

    branchUnit u_dut (
        .clk_i         (clk),
        .arstN_i       (arstN),
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .rsVal_i       (rsVal_i),
        .rtVal_i       (rtVal_i),
        .resValid_o    (resValid_o),
        .resPc_o       (resPc_o),
        .actualTaken_o (actualTaken_o),
        .mispredict_o  (mispredict_o),
        .redirectPc_o  (redirectPc_o)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkPc(input string name, input pcT expVal, input pcT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error %s: expected %h, actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error %s: expected %b, actual %b", name, expVal, actVal));
        end
    endtask

    // i-type word, rs field is don't-care here
    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [15:0] imm);
        return {op, 5'd3, rt, imm};
    endfunction

    task automatic addEntry(input string name, input pcT pc, input logic [31:0] instr,
                            input pcT rs, input pcT rt, input logic taken, input bit burst);
        tabName.push_back(name);
        tabPc.push_back(pc);
        tabInstr.push_back(instr);
        tabRs.push_back(rs);
        tabRt.push_back(rt);
        tabTaken.push_back(taken);
        tabBurst.push_back(burst);
    endtask

    task automatic buildTable();
        addEntry("beq taken fresh", 32'h0040_0000, encI(OP_BEQ, 5'd5, 16'h0010), 5, 5, 1, 0);
        addEntry("beq not taken", 32'h0040_0104, encI(OP_BEQ, 5'd2, 16'h0008), 1, 2, 0, 0);
        addEntry("bne taken", 32'h0040_0108, encI(OP_BNE, 5'd4, 16'hfffc), 3, 4, 1, 0);
        addEntry("bne not taken", 32'h0040_010c, encI(OP_BNE, 5'd7, 16'h0020), 7, 7, 0, 0);
        addEntry("blez taken negative", 32'h0040_0110, encI(OP_BLEZ, 5'd0, 16'hfff0),
                 32'hffff_fff0, 0, 1, 0);
        addEntry("blez taken zero", 32'h0040_0114, encI(OP_BLEZ, 5'd0, 16'h0004), 0, 0, 1, 0);
        addEntry("blez not taken", 32'h0040_0118, encI(OP_BLEZ, 5'd0, 16'h0004), 5, 0, 0, 0);
        addEntry("bgtz taken", 32'h0040_011c, encI(OP_BGTZ, 5'd0, 16'h0100), 1, 0, 1, 0);
        addEntry("bgtz not taken negative", 32'h0040_0120, encI(OP_BGTZ, 5'd0, 16'h0100),
                 32'h8000_0000, 0, 0, 0);
        addEntry("bgtz not taken zero", 32'h0040_0124, encI(OP_BGTZ, 5'd0, 16'h0002),
                 0, 0, 0, 0);
        addEntry("bltz taken", 32'h0040_0128, encI(OP_REGIMM, 5'b00000, 16'h8000),
                 32'hffff_ffff, 0, 1, 0);
        addEntry("bltz not taken", 32'h0040_012c, encI(OP_REGIMM, 5'b00000, 16'h0040),
                 0, 0, 0, 0);
        addEntry("bgez taken zero", 32'h0040_0130, encI(OP_REGIMM, 5'b00001, 16'h0040),
                 0, 0, 1, 0);
        addEntry("bgez not taken", 32'h0040_0134, encI(OP_REGIMM, 5'b00001, 16'h0040),
                 32'h8000_0001, 0, 0, 0);
        addEntry("bgez taken positive", 32'h0040_0138, encI(OP_REGIMM, 5'b00001, 16'h7fff),
                 32'h7fff_ffff, 0, 1, 0);
        // one pc trained up, then left
        addEntry("train 1", 32'h0040_02c0, encI(OP_BEQ, 5'd9, 16'h0030), 9, 9, 1, 0);
        addEntry("train 2", 32'h0040_02c0, encI(OP_BEQ, 5'd9, 16'h0030), 9, 9, 1, 0);
        addEntry("train 3", 32'h0040_02c0, encI(OP_BEQ, 5'd9, 16'h0030), 9, 9, 1, 0);
        addEntry("train exit", 32'h0040_02c0, encI(OP_BNE, 5'd9, 16'h0030), 9, 9, 0, 0);
        // index 16 shared by 0x340 and 0x440, issued back to back
        addEntry("burst a", 32'h0040_0340, encI(OP_BEQ, 5'd1, 16'h0011), 2, 2, 1, 0);
        addEntry("burst b", 32'h0040_0340, encI(OP_BEQ, 5'd1, 16'h0011), 2, 2, 1, 1);
        addEntry("burst alias", 32'h0040_0440, encI(OP_BNE, 5'd1, 16'hff00), 6, 6, 0, 1);
        addEntry("burst d", 32'h0040_0340, encI(OP_BEQ, 5'd1, 16'h0011), 2, 2, 1, 1);
        // non-branches, the first one on the trained index 48
        addEntry("addiu at trained index", 32'h0040_01c0, encI(6'b001001, 5'd1, 16'h0001),
                 1, 1, 0, 0);
        addEntry("branch after addiu", 32'h0040_02c0, encI(OP_BEQ, 5'd9, 16'h0030),
                 9, 9, 1, 1);
        addEntry("regimm link form", 32'h0040_0360, encI(OP_REGIMM, 5'b10001, 16'h0010),
                 0, 0, 0, 0);
        addEntry("lw not branch", 32'h0040_0364, encI(6'b100011, 5'd4, 16'h0004), 8, 8, 0, 0);
    endtask

    // reference: predict from counter, resolve, then train
    task automatic modelStep(input pcT pc, input logic [31:0] instr, input logic taken,
                             output logic miss, output pcT redir);
        idxT        idx;
        ctrT        ctr;
        logic [5:0] op;
        logic       isBr;
        pcT         target;
        idx    = pc[7:2];
        ctr    = refCtr[idx];
        op     = instr[31:26];
        isBr   = (op == 6'b000100) || (op == 6'b000101) || (op == 6'b000110) ||
                 (op == 6'b000111) ||
                 ((op == 6'b000001) && (instr[20:16] == 5'b00000 || instr[20:16] == 5'b00001));
        target = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        miss   = (isBr && ctr[1]) != taken;
        redir  = taken ? target : pc + 32'd`BR_SLOT_OFS;
        if (isBr && taken && ctr != 2'b11) begin
            refCtr[idx] = ctr + 2'd1;
        end else if (isBr && !taken && ctr != 2'b00) begin
            refCtr[idx] = ctr - 2'd1;
        end
    endtask

    task automatic driveCycle(input logic v, input logic s, input int e);
        @(posedge clk);
        #DriveDelay;
        valid_i = v;
        stall_i = s;
        if (e >= 0) begin
            pc_i    = tabPc[e];
            instr_i = tabInstr[e];
            rsVal_i = tabRs[e];
            rtVal_i = tabRt[e];
        end
    endtask

    task automatic checkResult();
        string name;
        pcT    pcExp;
        logic  takenExp;
        logic  missExp;
        pcT    redirExp;
        name     = expName.pop_front();
        pcExp    = expPc.pop_front();
        takenExp = expTaken.pop_front();
        missExp  = expMiss.pop_front();
        redirExp = expRedir.pop_front();
        checkPc({name, " resPc"}, pcExp, resPc_o);
        checkBit({name, " actualTaken"}, takenExp, actualTaken_o);
        checkBit({name, " mispredict"}, missExp, mispredict_o);
        checkPc({name, " redirectPc"}, redirExp, redirectPc_o);
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (arstN === 1'b1) begin
            if (resValid_o && expName.size() == 0) begin
                failRun("resValid_o went high with no instruction outstanding");
            end else if (resValid_o) begin
                checkResult();
            end else begin
                checkBit("idle mispredict_o", 1'b0, mispredict_o);
            end
        end
    end

    initial begin : watchdog
        int limitNs;
        wait (tableReady);
        limitNs = tabPc.size() * NumPasses * (MaxGap + 4) * ClkPeriod + MarginCycles * ClkPeriod;
        #(limitNs);
        failRun($sformatf("watchdog expired after %0d ns without finishing", limitNs));
    end

    initial begin : mainSeq
        logic [31:0] seedDummy;
        int          gaps;
        int          kind;
        int          drained;
        logic        miss;
        pcT          redir;
        valid_i    = 1'b0;
        stall_i    = 1'b0;
        pc_i       = '0;
        instr_i    = '0;
        rsVal_i    = '0;
        rtVal_i    = '0;
        tableReady = 1'b0;
        seedDummy  = $urandom(Seed);
        for (int i = 0; i < 64; i++) begin
            refCtr[i] = `BR_CTR_INIT;
        end
        buildTable();
        tableReady = 1'b1;

        wait (arstN === 1'b1);
        repeat (4) driveCycle(1'b0, 1'b0, -1);   // nothing may come out
        checkBit("reset idle resValid_o", 1'b0, resValid_o);

        for (int p = 1; p <= NumPasses; p++) begin
            for (int e = 0; e < tabPc.size(); e++) begin
                gaps = tabBurst[e] ? 0 : int'($urandom % (MaxGap + 1));
                for (int g = 0; g < gaps; g++) begin
                    kind = int'($urandom % 3);
                    if (kind == 0) driveCycle(1'b1, 1'b1, e);   // offered but blocked
                    else if (kind == 1) driveCycle(1'b0, 1'b1, -1);
                    else driveCycle(1'b0, 1'b0, -1);
                end
                modelStep(tabPc[e], tabInstr[e], tabTaken[e], miss, redir);
                expName.push_back($sformatf("%s (pass %0d)", tabName[e], p));
                expPc.push_back(tabPc[e]);
                expTaken.push_back(tabTaken[e]);
                expMiss.push_back(miss);
                expRedir.push_back(redir);
                driveCycle(1'b1, 1'b0, e);
            end
        end
        driveCycle(1'b0, 1'b0, -1);

        drained = 0;
        while (expName.size() != 0 && drained < DrainLimit) begin
            @(negedge clk);
            drained++;
        end
        @(posedge clk);
        if (expName.size() != 0) begin
            failRun($sformatf("%0d results never appeared on resValid_o", expName.size()));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- branchUnit.f
+incdir+logic
logic/branchPkg.sv
logic/predIf.sv
logic/branchPredictor.sv
logic/branchCondCheck.sv
logic/redirectUnit.sv
logic/branchUnit.sv
verification/clkGen.sv
verification/branchUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f branchUnit.f --top-module branchUnitTb -o simv

# the simulator exits nonzero on failure, the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
